/* Bender.yml */
package:
  name: conv_para_scale_fp16

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/conv_para_pkg.sv
      - verilog/fp16_mul.sv
      - verilog/fp16_add.sv
      - verilog/fp16_mac_lane.sv
      - verilog/activation_unit.sv
      - verilog/conv_kernel_ctrl.sv
      - verilog/conv_para_scale_fp16.sv
  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/conv_para_tb.sv

/* project.f */
+incdir+verilog
+incdir+tb
verilog/conv_para_pkg.sv
verilog/fp16_mul.sv
verilog/fp16_add.sv
verilog/fp16_mac_lane.sv
verilog/activation_unit.sv
verilog/conv_kernel_ctrl.sv
verilog/conv_para_scale_fp16.sv
tb/conv_para_tb.sv

/* tb/fp16_ref_model.svh */
`ifndef FP16_REF_MODEL_SVH
`define FP16_REF_MODEL_SVH

// builds a word from an unbounded exponent, flushing and saturating
function automatic fp16_t encode_fp16(input logic sign, input int e, input int frac);
	if (e <= 0) begin
		return 16'h0000;
	end else if (e >= 31) begin
		return {sign, 15'h7bff};
	end
	return {sign, 5'(e), 10'(frac)};
endfunction

function automatic fp16_t multiply_fp16(input fp16_t a, input fp16_t b);
	int prod;
	int e;
	if (a[14:10] == 5'd0 || b[14:10] == 5'd0) begin
		return 16'h0000;
	end
	prod = (1024 + int'(a[9:0])) * (1024 + int'(b[9:0]));
	e = int'(a[14:10]) + int'(b[14:10]) - 15;
	// product of two significands lies in [1, 4)
	if (prod >= (1 << 21)) begin
		prod = prod >> 1;
		e = e + 1;
	end
	return encode_fp16(a[15] ^ b[15], e, (prod >> 10) % 1024);
endfunction

function automatic fp16_t add_fp16(input fp16_t a, input fp16_t b);
	fp16_t hi;
	fp16_t lo;
	int mag_a;
	int mag_b;
	int m_hi;
	int m_lo;
	int sum;
	int msb;
	int frac;
	mag_a = (a[14:10] == 5'd0) ? 0 : int'(a[14:0]);
	mag_b = (b[14:10] == 5'd0) ? 0 : int'(b[14:0]);
	// on equal magnitudes a stays in front
	if (mag_b > mag_a) begin
		hi = b;
		lo = a;
	end else begin
		hi = a;
		lo = b;
	end
	m_hi = (hi[14:10] == 5'd0) ? 0 : 1024 + int'(hi[9:0]);
	m_lo = (lo[14:10] == 5'd0) ? 0 : 1024 + int'(lo[9:0]);
	m_lo = m_lo >> (int'(hi[14:10]) - int'(lo[14:10]));
	sum = (hi[15] == lo[15]) ? m_hi + m_lo : m_hi - m_lo;
	if (sum == 0) begin
		return 16'h0000;
	end
	msb = 0;
	while ((sum >> (msb + 1)) != 0) begin
		msb++;
	end
	if (msb > 10) begin
		frac = sum >> (msb - 10);
	end else begin
		frac = sum << (10 - msb);
	end
	return encode_fp16(hi[15], int'(hi[14:10]) + msb - 10, frac % 1024);
endfunction

function automatic fp16_t activate_fp16(input fp16_t v, input act_sel_t sel);
	case (sel)
		ACT_RELU: begin
			return v[15] ? 16'h0000 : v;
		end
		ACT_LEAKY: begin
			if (!v[15]) begin
				return v;
			end else if (v[14:10] <= 5'd3) begin
				return 16'h0000;
			end
			// exponent down by three is a divide by eight
			return v - 16'h0c00;
		end
		ACT_CLAMP: begin
			if (v[15]) begin
				return 16'h0000;
			end
			return (v > 16'h4600) ? 16'h4600 : v;
		end
		default: begin
			return v;
		end
	endcase
endfunction

`endif

/* tb/conv_para_tb.sv */
`default_nettype none

`include "conv_para_macros.svh"

module conv_para_tb
	import conv_para_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	`include "fp16_ref_model.svh"

	localparam int MAX_KS = 31;
	localparam int MAX_GAP = 4;
	localparam int N_RANDOM = 40;
	localparam int N_B2B = 20;
	localparam int N_ACT = 8;
	localparam int N_EDGE = 6;
	localparam int DRAIN_CYCLES = 3;
	// directed windows, idle stretches and resets
	localparam int N_WINDOWS = N_RANDOM + N_B2B + 4 * N_ACT + 3 * N_EDGE + 4;
	localparam int IDLE_CYCLES = 20;
	localparam int CYCLE_LIMIT = N_WINDOWS * (MAX_KS + MAX_GAP) + IDLE_CYCLES + 20;

	logic         clk;
	logic         rst_n;
	logic         in_valid;
	lane_grid_t   input_data;
	fp16_t        weight;
	kernel_size_t kernel_size;
	act_sel_t     activation;
	logic         result_valid;
	lane_grid_t   result_buffer;

	int         seed = 32'hdae5;
	int         cycle = 0;
	lane_grid_t model_acc;
	lane_grid_t exp_q[$];
	int         due_q[$];

	conv_para_scale_fp16 UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.input_data   (input_data),
		.weight       (weight),
		.kernel_size  (kernel_size),
		.activation   (activation),
		.result_valid (result_valid),
		.result_buffer(result_buffer)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic compare_word(input fp16_t want, input fp16_t got, input string name);
		if (got !== want) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, want, got);
			abort_run();
		end
	endtask

	task automatic compare_grid(input lane_grid_t want, input lane_grid_t got);
		for (int i = 0; i < `LANES; i++) begin
			compare_word(want.lane[i], got.lane[i], $sformatf("result_buffer.lane[%0d]", i));
		end
	endtask

	// exponent in lo..hi, or zero with the given odds in percent
	function automatic fp16_t random_word(input int lo, input int hi, input int zero_pct);
		int unsigned r;
		int e;
		r = $random(seed);
		if (r % 100 < zero_pct) begin
			return 16'h0000;
		end
		e = lo + int'(r[30:16] % (hi - lo + 1));
		return {r[31], 5'(e), r[9:0]};
	endfunction

	function automatic int random_below(input int n);
		int unsigned r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	task automatic drive_idle();
		@(negedge clk);
		in_valid = 1'b0;
		weight = random_word(1, 30, 0);
		for (int i = 0; i < `LANES; i++) begin
			input_data.lane[i] = random_word(1, 30, 0);
		end
		kernel_size = kernel_size_t'($random(seed));
		activation = act_sel_t'(random_below(4));
	endtask

	// two rising edges under reset, released on a falling edge
	task automatic apply_reset();
		rst_n = 1'b0;
		in_valid = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	endtask

	// one beat on the bus, with the window model stepped alongside
	task automatic send_beat(input lane_grid_t data, input fp16_t w, input kernel_size_t ks,
			input act_sel_t act, input logic first, input logic last);
		lane_grid_t want;
		fp16_t p;
		@(negedge clk);
		in_valid = 1'b1;
		input_data = data;
		weight = w;
		// size counts only on the first beat, the select only on the last
		kernel_size = first ? ks : kernel_size_t'($random(seed));
		if (last) begin
			activation = act;
		end else begin
			activation = act_sel_t'(random_below(4));
		end
		for (int i = 0; i < `LANES; i++) begin
			p = multiply_fp16(data.lane[i], w);
			model_acc.lane[i] = first ? p : add_fp16(model_acc.lane[i], p);
		end
		if (last) begin
			for (int i = 0; i < `LANES; i++) begin
				want.lane[i] = activate_fp16(model_acc.lane[i], act);
			end
			exp_q.push_back(want);
			// beat taken at the next edge, result seen three edges later
			due_q.push_back(cycle + 4);
		end
	endtask

	task automatic run_window(input kernel_size_t ks, input act_sel_t act, input int lo,
			input int hi, input int zero_pct, input int gap);
		lane_grid_t data;
		int len;
		len = (ks == '0) ? 1 : int'(ks);
		for (int b = 0; b < len; b++) begin
			for (int i = 0; i < `LANES; i++) begin
				data.lane[i] = random_word(lo, hi, zero_pct);
			end
			send_beat(data, random_word(lo, hi, zero_pct), ks, act, b == 0, b == len - 1);
		end
		repeat (gap) drive_idle();
	endtask

	// fully-connected style window, lane i holds i+1
	task automatic run_fc_case();
		lane_grid_t data;
		fp16_t counts[9] = '{16'h3c00, 16'h4000, 16'h4200, 16'h4400, 16'h4500,
			16'h4600, 16'h4700, 16'h4800, 16'h4880};
		for (int i = 0; i < `LANES; i++) begin
			data.lane[i] = counts[i % 9];
		end
		send_beat(data, 16'h3800, 5'd2, ACT_NONE, 1'b1, 1'b0);
		send_beat(data, 16'h3400, 5'd2, ACT_NONE, 1'b0, 1'b1);
		// 0.75 and 3.0 worked by hand
		compare_word(16'h3a00, exp_q[$].lane[0], "model lane 0");
		compare_word(16'h4200, exp_q[$].lane[3], "model lane 3");
		drive_idle();
	endtask

	task automatic run_cancel_case();
		lane_grid_t data;
		fp16_t w;
		for (int i = 0; i < `LANES; i++) begin
			data.lane[i] = random_word(12, 18, 0);
		end
		w = random_word(12, 18, 0);
		send_beat(data, w, 5'd2, ACT_NONE, 1'b1, 1'b0);
		send_beat(lane_grid_t'(data ^ {`LANES{16'h8000}}), w, 5'd2, ACT_NONE, 1'b0, 1'b1);
		for (int i = 0; i < `LANES; i++) begin
			compare_word(16'h0000, exp_q[$].lane[i], "model cancelled sum");
		end
	endtask

	task automatic run_reset_cut_case();
		lane_grid_t data;
		// earlier results out of the pipeline first
		repeat (DRAIN_CYCLES + 1) drive_idle();
		for (int b = 0; b < 4; b++) begin
			for (int i = 0; i < `LANES; i++) begin
				data.lane[i] = random_word(12, 18, 0);
			end
			send_beat(data, random_word(12, 18, 0), 5'd8, ACT_NONE, b == 0, 1'b0);
		end
		apply_reset();
	endtask

	always @(posedge clk) begin
		int due;
		cycle = cycle + 1;
		if (cycle > 1 && $isunknown(result_valid)) begin
			$display("result_valid is unknown at %0t after reset was applied", $time);
			abort_run();
		end
		if (result_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("result_valid rose at %0t with no window outstanding", $time);
				abort_run();
			end else begin
				due = due_q.pop_front();
				if (cycle != due) begin
					$display("ERROR at %0t: result_valid in cycle %0d, expected in cycle %0d",
						$time, cycle, due);
					abort_run();
				end
				compare_grid(exp_q.pop_front(), result_buffer);
			end
		end
		if (cycle > CYCLE_LIMIT) begin
			$display("run passed its limit of %0d cycles without finishing", CYCLE_LIMIT);
			abort_run();
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		input_data = '0;
		weight = '0;
		kernel_size = '0;
		activation = ACT_NONE;
		apply_reset();
		repeat (3) drive_idle();
		run_fc_case();
		repeat (N_RANDOM) begin
			run_window(kernel_size_t'(random_below(32)), act_sel_t'(random_below(4)), 12, 18, 5,
				random_below(MAX_GAP + 1));
		end
		// no gaps, sizes change every window
		repeat (N_B2B) begin
			run_window(kernel_size_t'(random_below(32)), ACT_NONE, 12, 18, 5, 0);
		end
		for (int a = 0; a < 4; a++) begin
			repeat (N_ACT) begin
				run_window(kernel_size_t'(random_below(32)), act_sel_t'(a), 13, 17, 10,
					random_below(MAX_GAP + 1));
			end
		end
		repeat (N_EDGE) begin
			run_window(kernel_size_t'(random_below(32)), ACT_NONE, 12, 18, 50, 1);
			run_window(kernel_size_t'(random_below(32)), ACT_NONE, 28, 30, 0, 1);
			run_window(kernel_size_t'(random_below(32)), ACT_NONE, 1, 4, 0, 1);
		end
		run_cancel_case();
		run_reset_cut_case();
		run_window(5'd3, ACT_RELU, 12, 18, 0, 0);
		// the last beat's own cycle plus the drain
		repeat (DRAIN_CYCLES + 1) drive_idle();
		if (exp_q.size() != 0) begin
			$display("%0d results still missing at the end of the run", exp_q.size());
			abort_run();
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/activation_unit.sv */
`default_nettype none

`include "conv_para_macros.svh"

module activation_unit
	import conv_para_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       grid_valid,
	input  act_sel_t   act,
	input  lane_grid_t grid,
	output logic       result_valid,
	output lane_grid_t result
);

	lane_grid_t act_grid;

	function automatic fp16_t apply_act(input fp16_t v, input act_sel_t sel);
		fp16_t r;
		r = v;
		case (sel)
			ACT_RELU: begin
				if (v[15]) r = 16'h0000;
			end
			ACT_LEAKY: begin
				// divide by 8 through the exponent, flush once it runs out
				if (v[15]) begin
					if (v[14:10] > 5'd3) r = {1'b1, v[14:10] - 5'd3, v[9:0]};
					else r = 16'h0000;
				end
			end
			ACT_CLAMP: begin
				if (v[15]) r = 16'h0000;
				else if (v[14:0] > `ACT_CLAMP_MAX) r = `ACT_CLAMP_MAX;
			end
			default: r = v;
		endcase
		return r;
	endfunction

	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			act_grid.lane[i] = apply_act(grid.lane[i], act);
		end
	end

	// stage 3 output register
	always_ff @(posedge clk) begin
		if (grid_valid) begin
			result <= act_grid;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= grid_valid;
		end
	end

endmodule

`default_nettype wire

/* verilog/conv_kernel_ctrl.sv */
`default_nettype none

module conv_kernel_ctrl
	import conv_para_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,
	input  kernel_size_t kernel_size,
	output logic         beat_first,
	output logic         beat_last
);

	ctrl_state_t  state;
	kernel_size_t beat_cnt;
	kernel_size_t ks_q;
	kernel_size_t ks_eff;

	// zero length behaves as a single beat
	assign ks_eff = (kernel_size == '0) ? kernel_size_t'(1) : kernel_size;

	assign beat_first = in_valid && (state == IDLE);

	always_comb begin
		if (state == IDLE) begin
			beat_last = in_valid && (ks_eff == kernel_size_t'(1));
		end else begin
			beat_last = in_valid && (beat_cnt + 1'b1 == ks_q);
		end
	end

	// ks_q only read in ACCUM, loaded on every first beat
	always_ff @(posedge clk) begin
		if (beat_first) begin
			ks_q <= ks_eff;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			beat_cnt <= '0;
		end else if (in_valid) begin
			if (beat_last) begin
				state    <= IDLE;
				beat_cnt <= '0;
			end else if (beat_first) begin
				state    <= ACCUM;
				beat_cnt <= kernel_size_t'(1);
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/conv_para_macros.svh */
`ifndef CONV_PARA_MACROS_SVH
`define CONV_PARA_MACROS_SVH

// lane grid dimensions
`define PARA_X 3
`define PARA_Y 3
`define LANES (`PARA_X * `PARA_Y)

// one half-precision word per lane
`define DATA_WIDTH 16

// window length field, 1 to 31 beats
`define KERNEL_SIZE_WIDTH 5

// largest finite fp16 magnitude, sign excluded
`define FP16_MAX_MAG 15'h7bff

// upper bound of the clamp activation (6.0)
`define ACT_CLAMP_MAX 16'h4600

`endif

/* verilog/conv_para_pkg.sv */
`default_nettype none

`include "conv_para_macros.svh"

package conv_para_pkg;

	// sign, 5-bit exponent, 10-bit fraction
	typedef logic [`DATA_WIDTH-1:0] fp16_t;

	// beats in one window
	typedef logic [`KERNEL_SIZE_WIDTH-1:0] kernel_size_t;

	typedef enum logic [1:0] {
		ACT_NONE  = 2'd0,
		ACT_RELU  = 2'd1,
		ACT_LEAKY = 2'd2,
		ACT_CLAMP = 2'd3
	} act_sel_t;

	// window controller
	typedef enum logic {
		IDLE  = 1'b0,
		ACCUM = 1'b1
	} ctrl_state_t;

	// lane 0 sits in the low bits
	typedef struct packed {
		fp16_t [`LANES-1:0] lane;
	} lane_grid_t;

endpackage

`default_nettype wire

/* verilog/conv_para_scale_fp16.sv */
`default_nettype none

`include "conv_para_macros.svh"

module conv_para_scale_fp16
	import conv_para_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,
	input  lane_grid_t   input_data,
	input  fp16_t        weight,
	input  kernel_size_t kernel_size,
	input  act_sel_t     activation,
	output logic         result_valid,
	output lane_grid_t   result_buffer
);

	logic               beat_first;
	logic               beat_last;
	logic [`LANES-1:0]  lane_done;
	logic               grid_valid;
	lane_grid_t         acc_grid;
	act_sel_t           act_d1;
	act_sel_t           act_d2;

	conv_kernel_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.kernel_size(kernel_size),
		.beat_first (beat_first),
		.beat_last  (beat_last)
	);

	// all lanes share the weight and the beat flags
	for (genvar i = 0; i < `LANES; i++) begin : g_lane
		fp16_mac_lane u_lane (
			.clk       (clk),
			.rst_n     (rst_n),
			.beat_valid(in_valid),
			.beat_first(beat_first),
			.beat_last (beat_last),
			.x         (input_data.lane[i]),
			.w         (weight),
			.acc       (acc_grid.lane[i]),
			.acc_done  (lane_done[i])
		);
	end

	// lanes run in lockstep, lane 0 speaks for the grid
	assign grid_valid = lane_done[0];

	// select lines up with the grid two edges after the last beat
	always_ff @(posedge clk) begin
		act_d1 <= activation;
		act_d2 <= act_d1;
	end

	activation_unit u_act (
		.clk         (clk),
		.rst_n       (rst_n),
		.grid_valid  (grid_valid),
		.act         (act_d2),
		.grid        (acc_grid),
		.result_valid(result_valid),
		.result      (result_buffer)
	);

endmodule

`default_nettype wire

/* verilog/fp16_add.sv */
`default_nettype none

`include "conv_para_macros.svh"

module fp16_add
	import conv_para_pkg::*;
(
	input  fp16_t a,
	input  fp16_t b,
	output fp16_t s
);

	logic [14:0]       mag_a;
	logic [14:0]       mag_b;
	logic              swap;
	fp16_t             big;
	fp16_t             lesser;
	logic [10:0]       m_big;
	logic [10:0]       m_small;
	logic [10:0]       m_shift;
	logic [4:0]        e_diff;
	logic [11:0]       sum;
	logic [3:0]        lead;
	logic [11:0]       norm;
	logic signed [6:0] exp_res;

	// exponent zero counts as zero whatever the fraction holds
	assign mag_a = (a[14:10] == 5'd0) ? 15'd0 : a[14:0];
	assign mag_b = (b[14:10] == 5'd0) ? 15'd0 : b[14:0];

	// larger magnitude first
	assign swap   = mag_b > mag_a;
	assign big    = swap ? b : a;
	assign lesser = swap ? a : b;

	assign m_big   = (big[14:10] == 5'd0) ? 11'd0 : {1'b1, big[9:0]};
	assign m_small = (lesser[14:10] == 5'd0) ? 11'd0 : {1'b1, lesser[9:0]};

	// alignment, no guard bits kept
	assign e_diff  = big[14:10] - lesser[14:10];
	assign m_shift = m_small >> e_diff;

	always_comb begin
		if (big[15] == lesser[15]) begin
			sum = {1'b0, m_big} + {1'b0, m_shift};
		end else begin
			sum = {1'b0, m_big} - {1'b0, m_shift};
		end
	end

	// position of the leading one
	always_comb begin
		lead = 4'd0;
		for (int i = 0; i < 12; i++) begin
			if (sum[i]) begin
				lead = i[3:0];
			end
		end
	end

	// carry out shifts right by one, cancellation shifts left
	always_comb begin
		if (lead == 4'd11) begin
			norm = sum >> 1;
		end else begin
			norm = sum << (4'd10 - lead);
		end
		exp_res = $signed({2'b00, big[14:10]}) + $signed({3'b000, lead}) - 7'sd10;
	end

	always_comb begin
		if (sum == 12'd0) begin
			// exact cancellation or two zeros
			s = 16'h0000;
		end else if (exp_res <= 7'sd0) begin
			s = 16'h0000;
		end else if (exp_res >= 7'sd31) begin
			s = {big[15], `FP16_MAX_MAG};
		end else begin
			s = {big[15], exp_res[4:0], norm[9:0]};
		end
	end

endmodule

`default_nettype wire

/* verilog/fp16_mac_lane.sv */
`default_nettype none

module fp16_mac_lane
	import conv_para_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  beat_valid,
	input  logic  beat_first,
	input  logic  beat_last,
	input  fp16_t x,
	input  fp16_t w,
	output fp16_t acc,
	output logic  acc_done
);

	fp16_t prod;
	fp16_t prod_q;
	fp16_t sum;
	logic  valid_q;
	logic  first_q;
	logic  last_q;

	fp16_mul u_mul (
		.a(x),
		.b(w),
		.p(prod)
	);

	fp16_add u_add (
		.a(acc),
		.b(prod_q),
		.s(sum)
	);

	// stage 1 product register
	always_ff @(posedge clk) begin
		prod_q <= prod;
	end

	// flags follow the product
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			first_q <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			valid_q <= beat_valid;
			first_q <= beat_valid & beat_first;
			last_q  <= beat_valid & beat_last;
		end
	end

	// stage 2, a first beat starts a fresh sum
	always_ff @(posedge clk) begin
		if (valid_q) begin
			acc <= first_q ? prod_q : sum;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_done <= 1'b0;
		end else begin
			acc_done <= valid_q & last_q;
		end
	end

endmodule

`default_nettype wire

/* verilog/fp16_mul.sv */
`default_nettype none

`include "conv_para_macros.svh"

module fp16_mul
	import conv_para_pkg::*;
(
	input  fp16_t a,
	input  fp16_t b,
	output fp16_t p
);

	logic              sign;
	logic [4:0]        ea;
	logic [4:0]        eb;
	logic [10:0]       ma;
	logic [10:0]       mb;
	logic [21:0]       prod;
	logic [9:0]        frac;
	logic signed [7:0] exp_res;

	assign sign = a[15] ^ b[15];
	assign ea   = a[14:10];
	assign eb   = b[14:10];

	// hidden one restored
	assign ma   = {1'b1, a[9:0]};
	assign mb   = {1'b1, b[9:0]};
	assign prod = ma * mb;

	// product of two 1.x values lies in [1, 4), so at most one place of shift
	always_comb begin
		if (prod[21]) begin
			frac    = prod[20:11];
			exp_res = $signed({3'b000, ea}) + $signed({3'b000, eb}) - 8'sd14;
		end else begin
			frac    = prod[19:10];
			exp_res = $signed({3'b000, ea}) + $signed({3'b000, eb}) - 8'sd15;
		end
	end

	always_comb begin
		if (ea == 5'd0 || eb == 5'd0) begin
			p = 16'h0000;
		end else if (exp_res <= 8'sd0) begin
			// flush to +0
			p = 16'h0000;
		end else if (exp_res >= 8'sd31) begin
			p = {sign, `FP16_MAX_MAG};
		end else begin
			p = {sign, exp_res[4:0], frac};
		end
	end

endmodule

`default_nettype wire
